/* Makefile */
TOP = uartTb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* common/byteFifoIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Byte queue link between register block and serializer
interface byteFifoIf;

  logic       push;    // Writer strobe
  logic [7:0] wrData;
  logic       full;
  logic       empty;
  logic       pop;     // Reader strobe
  logic [7:0] rdData;  // Head entry

  // Register block side
  modport writer (output push, wrData, input full, empty);

  // Serializer side
  modport reader (output pop, input rdData, empty);

  // Queue storage side
  modport fifo (input push, wrData, pop, output full, empty, rdData);

endinterface

`default_nettype wire

/* common/uartPkg.sv */
`default_nettype none

package uartPkg;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam logic [1:0] brgAddr = 2'd0;  // Baud divisor
  localparam logic [1:0] ctlAddr = 2'd1;  // Control
  localparam logic [1:0] txrAddr = 2'd2;  // Write queues a byte
  localparam logic [1:0] rxrAddr = 2'd3;  // Last received byte

  //////////////////////////////////////////////////
  // Transmit queue sizing
  //////////////////////////////////////////////////

  localparam int txFifoDepth = 8;
  localparam int txFifoPtrW  = 3;  // log2 of depth

  //////////////////////////////////////////////////
  // Status word bit positions
  //////////////////////////////////////////////////

  localparam int stTxBusy    = 0;
  localparam int stFifoEmpty = 1;
  localparam int stFifoFull  = 2;
  localparam int stRxValid   = 3;
  localparam int stRxOverrun = 4;  // Sticky until status read
  localparam int stFrameErr  = 5;  // Sticky until status read

  // 8N1 frame as it sits on the line
  // Raw view shifts out or in with bit 0 first
  typedef union packed {
    logic [9:0] raw;
    struct packed {
      logic       stop;   // High end
      logic [7:0] data;   // LSB goes out first
      logic       start;  // Low end
    } fields;
  } uartFrameU;

endpackage

`default_nettype wire

/* hw/uartRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module uartRegs (
  input  logic        clk,
  input  logic        rstN,
  input  logic        busEn,       // Access strobe
  input  logic        busWr,       // High for write
  input  logic [1:0]  busAddr,
  input  logic [15:0] busWrData,
  output logic [15:0] busRdData,
  byteFifoIf.writer   fifo,
  input  logic        txBusy,
  input  logic [7:0]  rxByte,
  input  logic        rxDone,
  input  logic        rxFrameErr,
  output logic [15:0] brgDiv,
  output logic        uartEn,
  output logic        rxInt
);
  import uartPkg::*;

  logic        regWr;
  logic        regRd;
  logic        rxRdClr;     // Read of receive register
  logic        statRdClr;   // Read of status register
  logic [7:0]  rxData;
  logic        rxValid;
  logic        rxOverrun;
  logic        frameErr;
  logic [15:0] statusWord;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign regWr     = busEn & busWr;
  assign regRd     = busEn & ~busWr;
  assign rxRdClr   = regRd & (busAddr == rxrAddr);
  assign statRdClr = regRd & (busAddr == txrAddr);

  // Address 2 write goes straight into the queue
  assign fifo.push   = regWr & (busAddr == txrAddr);
  assign fifo.wrData = busWrData[7:0];  // Upper byte ignored

  assign rxInt = rxDone;  // Interrupt per good byte

  // Divisor and enable
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      brgDiv <= '0;
      uartEn <= 1'b0;
    end else if (regWr) begin
      if (busAddr == brgAddr) brgDiv <= busWrData;
      if (busAddr == ctlAddr) uartEn <= busWrData[0];  // Only bit 0 kept
    end
  end

  //////////////////////////////////////////////////
  // Receive side flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxValid   <= 1'b0;
      rxOverrun <= 1'b0;
      frameErr  <= 1'b0;
    end else begin
      // New byte wins over a clearing read
      if (rxDone) rxValid <= 1'b1;
      else if (rxRdClr) rxValid <= 1'b0;

      // Unread byte being replaced
      if (rxDone && rxValid && !rxRdClr) rxOverrun <= 1'b1;
      else if (statRdClr) rxOverrun <= 1'b0;

      if (rxFrameErr) frameErr <= 1'b1;  // Bad stop bit
      else if (statRdClr) frameErr <= 1'b0;
    end
  end

  // Byte holding register
  always_ff @(posedge clk) begin
    if (rxDone) rxData <= rxByte;
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    statusWord              = '0;
    statusWord[stTxBusy]    = txBusy;
    statusWord[stFifoEmpty] = fifo.empty;
    statusWord[stFifoFull]  = fifo.full;
    statusWord[stRxValid]   = rxValid;
    statusWord[stRxOverrun] = rxOverrun;
    statusWord[stFrameErr]  = frameErr;
  end

  always_comb begin
    case (busAddr)
      brgAddr: busRdData = brgDiv;
      ctlAddr: busRdData = {15'd0, uartEn};
      txrAddr: busRdData = statusWord;          // Status on read
      rxrAddr: busRdData = {8'd0, rxData};
      default: busRdData = '0;
    endcase
  end

  // One bus access is either a push or a clearing read
  aPushNoClear: assert property (@(posedge clk) disable iff (!rstN)
    !(fifo.push && (rxRdClr || statRdClr)));

endmodule

`default_nettype wire

/* hw/uartTop.sv */
`timescale 1ns/1ps
`default_nettype none

module uartTop (
  input  logic        clk,
  input  logic        rstN,
  input  logic        busEn,
  input  logic        busWr,
  input  logic [1:0]  busAddr,
  input  logic [15:0] busWrData,
  output logic [15:0] busRdData,
  output logic        txOut,
  output logic        txInt,
  input  logic        rxIn,
  output logic        rxInt
);

  logic [15:0] brgDiv;
  logic        uartEn;
  logic        txBusy;
  logic [7:0]  rxByte;
  logic        rxDone;
  logic        rxFrameErr;

  byteFifoIf fifoBus ();  // Registers to serializer path

  //////////////////////////////////////////////////
  // Producer queue and consumer
  //////////////////////////////////////////////////

  uartRegs uartRegs_inst (
    .clk        (clk),
    .rstN       (rstN),
    .busEn      (busEn),
    .busWr      (busWr),
    .busAddr    (busAddr),
    .busWrData  (busWrData),
    .busRdData  (busRdData),
    .fifo       (fifoBus.writer),
    .txBusy     (txBusy),
    .rxByte     (rxByte),
    .rxDone     (rxDone),
    .rxFrameErr (rxFrameErr),
    .brgDiv     (brgDiv),
    .uartEn     (uartEn),
    .rxInt      (rxInt)
  );

  txFifo txFifo_inst (
    .clk  (clk),
    .rstN (rstN),
    .fifo (fifoBus.fifo)
  );

  uartTx uartTx_inst (
    .clk    (clk),
    .rstN   (rstN),
    .fifo   (fifoBus.reader),
    .brgDiv (brgDiv),
    .uartEn (uartEn),
    .txBusy (txBusy),
    .txOut  (txOut),
    .txInt  (txInt)
  );

  // Receiver beside the transmit chain
  uartRx uartRx_inst (
    .clk        (clk),
    .rstN       (rstN),
    .rxIn       (rxIn),
    .brgDiv     (brgDiv),
    .uartEn     (uartEn),
    .rxByte     (rxByte),
    .rxDone     (rxDone),
    .rxFrameErr (rxFrameErr)
  );

endmodule

`default_nettype wire

/* project.f */
common/uartPkg.sv
common/byteFifoIf.sv
hw/uartRegs.sv
uart/txFifo.sv
uart/uartTx.sv
uart/uartRx.sv
hw/uartTop.sv
test/uartTb.sv

/* test/uartTb.sv */
`timescale 1ns/1ps
`default_nettype none

module uartTb;
  import uartPkg::*;

  localparam int tbDiv     = 7;      // Divisor for all frame tests
  localparam int seed      = 40894;
  localparam int maxCycles = 30000;  // About 30 frames plus waits

  logic clk, rstN, busEn, busWr, txOut, txInt, rxIn, rxInt;
  logic [1:0]  busAddr;
  logic [15:0] busWrData, busRdData;
  logic        loopMode;  // High ties txOut back to rxIn
  logic        rxDrv;     // Line level from the frame task
  logic [7:0]  expTx[$];  // Bytes accepted by the queue, in order
  int cycleCnt, pushCnt, startCnt, doneCnt, rxIntCnt;

  uartTop uartTop_inst (.clk(clk), .rstN(rstN), .busEn(busEn), .busWr(busWr),
    .busAddr(busAddr), .busWrData(busWrData), .busRdData(busRdData),
    .txOut(txOut), .txInt(txInt), .rxIn(rxIn), .rxInt(rxInt));

  assign rxIn = loopMode ? txOut : rxDrv;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Expected line level of an 8N1 frame
  function automatic logic frameBit(input logic [7:0] data, input int idx);
    if (idx == 0) return 1'b0;        // Start
    else if (idx == 9) return 1'b1;   // Stop
    else return data[idx-1];          // LSB first
  endfunction

  function automatic logic [15:0] statusFor(input int pushes, input int started,
      input int sent, input logic rxV, input logic ovr, input logic fe);
    int queued;
    logic [15:0] word;
    queued = pushes - started;  // Still waiting in the queue
    word = '0;
    word[stTxBusy]    = (started != sent);
    word[stFifoEmpty] = (queued == 0);
    word[stFifoFull]  = (queued >= txFifoDepth);
    word[stRxValid]   = rxV;
    word[stRxOverrun] = ovr;
    word[stFrameErr]  = fe;
    return word;
  endfunction

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0d ns %s: got %0h expected %0h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  //////////////////////////////////////////////////
  // Bus and line tasks
  //////////////////////////////////////////////////

  task automatic busWrite(input logic [1:0] addr, input logic [15:0] data);
    @(negedge clk);
    busEn     = 1'b1;
    busWr     = 1'b1;
    busAddr   = addr;
    busWrData = data;
    @(negedge clk);
    busEn = 1'b0;
    busWr = 1'b0;
  endtask

  task automatic busRead(input logic [1:0] addr, output logic [15:0] data);
    @(negedge clk);
    busEn   = 1'b1;
    busWr   = 1'b0;
    busAddr = addr;
    #1 data = busRdData;  // Combinational read, well before the edge
    @(negedge clk);
    busEn = 1'b0;
  endtask

  // Queue model drops a byte when eight are waiting
  task automatic pushByte(input logic [7:0] data);
    if (pushCnt - startCnt < txFifoDepth) begin
      expTx.push_back(data);
      pushCnt++;
    end
    busWrite(txrAddr, {8'h00, data});
  endtask

  task automatic checkStatus(input string what, input logic rxV, input logic ovr,
      input logic fe);
    logic [15:0] word;
    busRead(txrAddr, word);
    checkEq(what, word, statusFor(pushCnt, startCnt, doneCnt, rxV, ovr, fe));
  endtask

  task automatic waitTxDone(input int target);
    while (doneCnt < target) @(negedge clk);
  endtask

  task automatic sendFrame(input logic [7:0] data, input logic stopLevel);
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rxDrv = (i == 9) ? stopLevel : frameBit(data, i);
      repeat (tbDiv) @(negedge clk);  // Hold one bit period
    end
    @(negedge clk);
    rxDrv = 1'b1;
    repeat (2 * (tbDiv + 1)) @(negedge clk);  // Idle gap
  endtask

  //////////////////////////////////////////////////
  // Monitors and watchdog
  //////////////////////////////////////////////////

  initial begin : txMonitor
    logic [7:0] expByte;
    forever begin
      do @(negedge clk); while (rstN !== 1'b1 || txOut !== 1'b0);  // Start bit
      startCnt++;
      checkEq("frame with a queued byte", expTx.size() != 0, 1);
      expByte = expTx.pop_front();
      repeat ((tbDiv + 1) / 2) @(negedge clk);  // To bit center
      for (int b = 0; b < 10; b++) begin
        checkEq($sformatf("txOut bit %0d of %h", b, expByte), txOut, frameBit(expByte, b));
        if (b != 9) repeat (tbDiv + 1) @(negedge clk);
      end
    end
  end

  always @(negedge clk) begin
    if (txInt === 1'b1) doneCnt++;
    if (rxInt === 1'b1) rxIntCnt++;
  end

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt >= maxCycles) begin
      $display("Timeout: tests did not finish within %0d cycles", maxCycles);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [15:0] rd;
    logic [7:0]  b, b2;
    int rxExp;
    {busEn, busWr, busAddr, busWrData} = '0;
    {cycleCnt, pushCnt, startCnt, doneCnt, rxIntCnt, rxExp} = '0;
    loopMode = 1'b0;
    rxDrv    = 1'b1;
    rstN     = 1'b0;
    void'($urandom(seed));
    repeat (10) @(posedge clk);
    @(negedge clk) rstN = 1'b1;

    // Reset values and readback
    checkEq("txOut after reset", txOut, 1'b1);
    checkStatus("status after reset", 0, 0, 0);
    busWrite(brgAddr, 16'h1234);
    busRead(brgAddr, rd);
    checkEq("divisor readback", rd, 16'h1234);
    busWrite(ctlAddr, 16'hfffe);
    busRead(ctlAddr, rd);
    checkEq("control bit 0 only", rd, 16'h0000);
    busWrite(brgAddr, 16'(tbDiv));
    busWrite(ctlAddr, 16'h0001);
    busRead(ctlAddr, rd);
    checkEq("control enabled", rd, 16'h0001);

    // Frame format with random bytes
    repeat (5) pushByte(8'($urandom()));
    waitTxDone(pushCnt);
    repeat (tbDiv + 1) @(negedge clk);  // Room for a stray second pulse
    checkEq("one txInt per byte", doneCnt, pushCnt);
    checkStatus("status after frames", 0, 0, 0);

    // Fill while disabled, ninth byte dropped
    busWrite(ctlAddr, 16'h0000);
    for (int i = 0; i < 9; i++) begin
      pushByte(8'($urandom()));
      checkStatus($sformatf("status after write %0d", i + 1), 0, 0, 0);
    end
    busWrite(ctlAddr, 16'h0001);
    while (startCnt < pushCnt - 7) @(negedge clk);
    checkStatus("status while sending", 0, 0, 0);  // Busy with seven left
    waitTxDone(pushCnt);
    repeat (20 * (tbDiv + 1)) @(negedge clk);  // No ninth frame
    checkEq("frames after fill", startCnt, pushCnt);
    checkStatus("status after drain", 0, 0, 0);

    // Loopback receive
    @(negedge clk) loopMode = 1'b1;
    repeat (4) begin
      b = 8'($urandom());
      pushByte(b);
      rxExp++;
      waitTxDone(pushCnt);
      while (rxIntCnt < rxExp) @(negedge clk);
      checkStatus("rx byte waiting", 1, 0, 0);
      busRead(rxrAddr, rd);
      checkEq("loopback byte", rd, {8'h00, b});
      checkStatus("rx read clears valid", 0, 0, 0);
    end

    // Overrun and framing error
    @(negedge clk) loopMode = 1'b0;
    b  = 8'($urandom());
    b2 = 8'($urandom());
    sendFrame(b, 1'b1);
    sendFrame(b2, 1'b1);
    rxExp += 2;
    while (rxIntCnt < rxExp) @(negedge clk);
    checkStatus("overrun set", 1, 1, 0);
    busRead(rxrAddr, rd);
    checkEq("second byte kept", rd, {8'h00, b2});
    sendFrame(8'($urandom()), 1'b0);  // Stop bit low
    checkStatus("frame error set", 0, 0, 1);
    checkStatus("flags cleared by status read", 0, 0, 0);

    // Disable holds the queue and the line
    busWrite(ctlAddr, 16'h0000);
    repeat (3) pushByte(8'($urandom()));
    repeat (300) begin
      @(negedge clk);
      checkEq("txOut while disabled", txOut, 1'b1);
    end
    checkStatus("queue kept while disabled", 0, 0, 0);
    busWrite(ctlAddr, 16'h0001);
    waitTxDone(pushCnt);
    checkStatus("status after re-enable", 0, 0, 0);
    checkEq("rxInt count", rxIntCnt, rxExp);
    checkEq("txInt count", doneCnt, pushCnt);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* uart/txFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module txFifo (
  input  logic    clk,
  input  logic    rstN,
  byteFifoIf.fifo fifo
);
  import uartPkg::*;

  logic [7:0]            mem [txFifoDepth];
  logic [txFifoPtrW-1:0] wrPtr;
  logic [txFifoPtrW-1:0] rdPtr;
  logic [txFifoPtrW:0]   count;   // One extra bit for full
  logic                  doPush;
  logic                  doPop;

  //////////////////////////////////////////////////
  // Strobe qualification
  //////////////////////////////////////////////////

  assign doPush = fifo.push & ~fifo.full;   // Push into full queue dropped
  assign doPop  = fifo.pop & ~fifo.empty;

  assign fifo.full   = (count == (txFifoPtrW + 1)'(txFifoDepth));
  assign fifo.empty  = (count == '0);
  assign fifo.rdData = mem[rdPtr];          // Head visible without a pop

  // Storage
  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= fifo.wrData;
  end

  //////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;  // Wraps at depth
      if (doPop) rdPtr <= rdPtr + 1'b1;

      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // Both or neither
      endcase
    end
  end

  // Fill level stays within storage
  aCountBound: assert property (@(posedge clk) disable iff (!rstN)
    count <= (txFifoPtrW + 1)'(txFifoDepth));

  // Serializer only pops when it saw a byte waiting
  aNoPopEmpty: assert property (@(posedge clk) disable iff (!rstN)
    fifo.pop |-> !fifo.empty);

endmodule

`default_nettype wire

/* uart/uartRx.sv */
`timescale 1ns/1ps
`default_nettype none

module uartRx (
  input  logic        clk,
  input  logic        rstN,
  input  logic        rxIn,
  input  logic [15:0] brgDiv,
  input  logic        uartEn,
  output logic [7:0]  rxByte,
  output logic        rxDone,
  output logic        rxFrameErr
);
  import uartPkg::*;

  logic [1:0]  rxSync;      // Two flop synchronizer
  logic        rxPrev;      // For edge detect
  logic        rxBit;
  logic        rxFall;
  logic        receiving;
  logic        firstHalf;   // Waiting for start bit center
  logic [15:0] baudCnt;
  logic [3:0]  bitCnt;      // Samples taken
  logic [16:0] halfSpan;
  logic [15:0] sampleLim;
  logic        sampleNow;
  uartFrameU   rxFrame;
  uartFrameU   frameNext;

  //////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxSync <= 2'b11;  // Idle line level
      rxPrev <= 1'b1;
    end else begin
      rxSync <= {rxSync[0], rxIn};
      rxPrev <= rxSync[1];
    end
  end

  assign rxBit  = rxSync[1];
  assign rxFall = rxPrev & ~rxBit;

  // Half period first and whole periods after
  assign halfSpan = ({1'b0, brgDiv} + 17'd1) >> 1;

  always_comb begin
    if (!firstHalf) sampleLim = brgDiv;
    else if (halfSpan == 17'd0) sampleLim = '0;  // Divisor of zero
    else sampleLim = halfSpan[15:0] - 16'd1;
  end

  assign sampleNow = receiving & (baudCnt == sampleLim);

  always_comb begin
    frameNext.raw = {rxBit, rxFrame.raw[9:1]};  // Newest sample at top
  end

  //////////////////////////////////////////////////
  // Receive FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      receiving  <= 1'b0;
      firstHalf  <= 1'b0;
      baudCnt    <= '0;
      bitCnt     <= '0;
      rxDone     <= 1'b0;
      rxFrameErr <= 1'b0;
    end else begin
      rxDone     <= 1'b0;
      rxFrameErr <= 1'b0;
      if (!uartEn) begin
        receiving <= 1'b0;
        baudCnt   <= '0;
        bitCnt    <= '0;
      end else if (!receiving) begin
        if (rxFall) begin  // Start edge
          receiving <= 1'b1;
          firstHalf <= 1'b1;
          baudCnt   <= '0;
          bitCnt    <= '0;
        end
      end else if (sampleNow) begin
        baudCnt   <= '0;
        firstHalf <= 1'b0;
        bitCnt    <= bitCnt + 4'd1;
        if (firstHalf && rxBit) begin
          receiving <= 1'b0;  // Glitch so drop quietly
        end else if (bitCnt == 4'd9) begin
          receiving  <= 1'b0;
          rxDone     <= frameNext.fields.stop & ~frameNext.fields.start;
          rxFrameErr <= ~frameNext.fields.stop;
        end
      end else begin
        baudCnt <= baudCnt + 16'd1;
      end
    end
  end

  // Sample shift and byte capture
  always_ff @(posedge clk) begin
    if (sampleNow) rxFrame <= frameNext;
    if (sampleNow && bitCnt == 4'd9) rxByte <= frameNext.fields.data;
  end

endmodule

`default_nettype wire

/* uart/uartTx.sv */
`timescale 1ns/1ps
`default_nettype none

module uartTx (
  input  logic        clk,
  input  logic        rstN,
  byteFifoIf.reader   fifo,
  input  logic [15:0] brgDiv,
  input  logic        uartEn,
  output logic        txBusy,
  output logic        txOut,
  output logic        txInt
);
  import uartPkg::*;

  logic        shifting;    // FSM state, low when idle
  logic [15:0] baudCnt;     // Cycles into current bit
  logic [3:0]  bitCnt;      // Bits already sent
  uartFrameU   txFrame;     // Bit 0 drives the line
  logic        startXmit;
  logic        baudTick;
  logic        lastBit;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  assign startXmit = ~shifting & uartEn & ~fifo.empty;
  assign baudTick  = shifting & (baudCnt == brgDiv);  // End of a bit period
  assign lastBit   = (bitCnt == 4'd9);                // Stop bit on the line

  assign fifo.pop = startXmit;  // Pop in the start cycle

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shifting    <= 1'b0;
      baudCnt     <= '0;
      bitCnt      <= '0;
      txFrame.raw <= '1;  // Line idles high
      txInt       <= 1'b0;
    end else begin
      txInt <= 1'b0;
      if (!uartEn) begin
        // Abort any frame and idle the line
        shifting    <= 1'b0;
        baudCnt     <= '0;
        bitCnt      <= '0;
        txFrame.raw <= '1;
      end else if (startXmit) begin
        shifting             <= 1'b1;
        baudCnt              <= '0;
        bitCnt               <= '0;
        txFrame.fields.start <= 1'b0;
        txFrame.fields.data  <= fifo.rdData;
        txFrame.fields.stop  <= 1'b1;
      end else if (baudTick) begin
        baudCnt     <= '0;
        txFrame.raw <= {1'b1, txFrame.raw[9:1]};  // Next bit out and fill with idle
        if (lastBit) begin
          shifting <= 1'b0;
          bitCnt   <= '0;
          txInt    <= 1'b1;  // Cycle after stop bit
        end else begin
          bitCnt <= bitCnt + 4'd1;
        end
      end else if (shifting) begin
        baudCnt <= baudCnt + 16'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign txOut  = txFrame.raw[0];
  assign txBusy = shifting;

  // Frame fully drained by the time the FSM idles
  aIdleHigh: assert property (@(posedge clk) disable iff (!rstN)
    !shifting |-> txOut);

endmodule

`default_nettype wire
